// File: include/ps2_consts.svh
// --------------------
// PS/2 mouse front end constants
// line timing, command bytes and cursor limits
// --------------------
`ifndef PS2_CONSTS_SVH
`define PS2_CONSTS_SVH

// identical samples before the filtered device clock may change
`define PS2_FILT_CYCLES 4

// host clock inhibit before request-to-send, 100 us at 10 MHz
`define PS2_INHIBIT_CYCLES 1000

// idle clk cycles inside a frame before it is abandoned
`define PS2_FRAME_TIMEOUT 20000

// host command and device answer
`define PS2_CMD_ENABLE 8'hF4
`define PS2_ACK_BYTE 8'hFA

// default cursor rectangle and position width
`define PS2_MAX_X 1023
`define PS2_MAX_Y 767
`define PS2_POS_W 12

`endif

// File: design/ps2_pkg.sv
// --------------------
// PS/2 mouse types
// buttons, motion packet and cursor position
// --------------------
`include "ps2_consts.svh"

package ps2_pkg;

  // button levels, 1 = pressed
  typedef struct packed {
    logic left;
    logic middle;
    logic right;
  } mouse_btn_t;

  // overflow flags from the packet header
  typedef struct packed {
    logic x_ovf;
    logic y_ovf;
  } mouse_ovf_t;

  // one decoded movement packet
  // dx and dy are 9-bit two's complement, sign taken from byte 0
  typedef struct packed {
    mouse_btn_t btn;
    logic [8:0] dx;
    logic [8:0] dy;
    mouse_ovf_t ovf;
  } mouse_motion_t;

  // absolute cursor position, y grows downward
  typedef struct packed {
    logic [`PS2_POS_W-1:0] x;
    logic [`PS2_POS_W-1:0] y;
  } xy_pos_t;

endpackage

// File: design/ps2_frame_rx.sv
// --------------------
// PS/2 frame receiver
// filters the device clock, shifts in 11-bit device-to-host frames
// --------------------
`timescale 1ns/10ps
`include "ps2_consts.svh"

module ps2_frame_rx (
  input  logic       clk,
  input  logic       arst_n,
  input  logic       ps2_clk_in,
  input  logic       ps2_data_in,
  input  logic       tx_busy,
  output logic [7:0] rx_byte,
  output logic       rx_valid,
  output logic       rx_err,
  output logic       clk_fall
);

  localparam int FILT_W = $clog2(`PS2_FILT_CYCLES) + 1;
  localparam int TO_W   = $clog2(`PS2_FRAME_TIMEOUT) + 1;

  logic [1:0]        clk_sync;
  logic [1:0]        data_sync;
  logic              clk_filt;
  logic              clk_filt_d;
  logic [FILT_W-1:0] filt_cnt;
  logic [9:0]        shift_q;
  logic [3:0]        bit_cnt;
  logic [TO_W-1:0]   idle_cnt;
  logic              frame_ok;

  // two-flop synchronizers, lines idle high
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      clk_sync  <= 2'b11;
      data_sync <= 2'b11;
    end else begin
      clk_sync  <= {clk_sync[0], ps2_clk_in};
      data_sync <= {data_sync[0], ps2_data_in};
    end
  end

  // clock glitch filter
  // level changes only after FILT_CYCLES samples in a row disagree
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      clk_filt   <= 1'b1;
      clk_filt_d <= 1'b1;
      filt_cnt   <= '0;
    end else begin
      clk_filt_d <= clk_filt;
      if (clk_sync[1] == clk_filt) begin
        filt_cnt <= '0;
      end else if (filt_cnt == FILT_W'(`PS2_FILT_CYCLES - 1)) begin
        clk_filt <= clk_sync[1];
        filt_cnt <= '0;
      end else begin
        filt_cnt <= filt_cnt + 1'b1;
      end
    end
  end

  // one-cycle strobe, also used by the transmitter
  assign clk_fall = clk_filt_d & ~clk_filt;

  // start low, stop high, odd parity over data and parity bit
  // shift_q[0] holds the start bit once ten bits are in
  assign frame_ok = ~shift_q[0] & data_sync[1] & (^shift_q[9:1]);

  // bit counter, idle timeout and result strobes
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      bit_cnt  <= '0;
      idle_cnt <= '0;
      rx_valid <= 1'b0;
      rx_err   <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      rx_err   <= 1'b0;
      if (tx_busy) begin
        // host owns the lines, drop anything partial
        bit_cnt  <= '0;
        idle_cnt <= '0;
      end else if (clk_fall) begin
        idle_cnt <= '0;
        if (bit_cnt == 4'd10) begin
          // stop bit is on the line now
          bit_cnt  <= '0;
          rx_valid <= frame_ok;
          rx_err   <= ~frame_ok;
        end else begin
          bit_cnt <= bit_cnt + 4'd1;
        end
      end else if (bit_cnt != 4'd0) begin
        if (idle_cnt == TO_W'(`PS2_FRAME_TIMEOUT - 1)) begin
          bit_cnt  <= '0;
          idle_cnt <= '0;
          rx_err   <= 1'b1;
        end else begin
          idle_cnt <= idle_cnt + 1'b1;
        end
      end
    end
  end

  // frame bits enter at the top, LSB first on the wire
  always_ff @(posedge clk) begin
    if (clk_fall && bit_cnt != 4'd10) begin
      shift_q <= {data_sync[1], shift_q[9:1]};
    end
    if (clk_fall && bit_cnt == 4'd10) begin
      rx_byte <= shift_q[8:1];
    end
  end

endmodule

// File: design/ps2_cmd_tx.sv
// --------------------
// PS/2 host command transmitter
// request-to-send, one command byte, line acknowledge check
// --------------------
`timescale 1ns/10ps
`include "ps2_consts.svh"

module ps2_cmd_tx (
  input  logic clk,
  input  logic arst_n,
  input  logic tx_start,
  input  logic clk_fall,
  input  logic ps2_data_in,
  output logic ps2_clk_oe,
  output logic ps2_data_oe,
  output logic tx_busy,
  output logic tx_done,
  output logic tx_noack
);

  localparam int TMR_W = $clog2(`PS2_FRAME_TIMEOUT) + 1;

  typedef enum logic [2:0] {
    IDLE,
    INHIBIT,
    REQ,
    SEND,
    ACK
  } tx_state_t;

  tx_state_t        state;
  logic [1:0]       data_sync;
  logic [8:0]       tx_shift;
  logic [3:0]       bit_cnt;
  logic [TMR_W-1:0] tmr;
  logic             timed_out;

  assign tx_busy   = (state != IDLE);
  assign timed_out = (tmr == TMR_W'(`PS2_FRAME_TIMEOUT - 1));

  // ack is read from the data line
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      data_sync <= 2'b11;
    end else begin
      data_sync <= {data_sync[0], ps2_data_in};
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state       <= IDLE;
      ps2_clk_oe  <= 1'b0;
      ps2_data_oe <= 1'b0;
      bit_cnt     <= '0;
      tmr         <= '0;
      tx_done     <= 1'b0;
      tx_noack    <= 1'b0;
    end else begin
      tx_done  <= 1'b0;
      tx_noack <= 1'b0;
      case (state)
        IDLE: begin
          if (tx_start) begin
            // hold the clock low to get the device's attention
            ps2_clk_oe <= 1'b1;
            tmr        <= '0;
            state      <= INHIBIT;
          end
        end
        INHIBIT: begin
          if (tmr == TMR_W'(`PS2_INHIBIT_CYCLES - 1)) begin
            // start bit goes out before the clock is let go
            ps2_data_oe <= 1'b1;
            tmr         <= '0;
            state       <= REQ;
          end else begin
            tmr <= tmr + 1'b1;
          end
        end
        REQ: begin
          ps2_clk_oe <= 1'b0;
          bit_cnt    <= '0;
          state      <= SEND;
        end
        SEND: begin
          if (clk_fall) begin
            // d0..d7, parity, then stop released on the 10th fall
            ps2_data_oe <= ~tx_shift[0];
            bit_cnt     <= bit_cnt + 4'd1;
            tmr         <= '0;
            if (bit_cnt == 4'd9) begin
              state <= ACK;
            end
          end else if (timed_out) begin
            ps2_data_oe <= 1'b0;
            tx_noack    <= 1'b1;
            state       <= IDLE;
          end else begin
            tmr <= tmr + 1'b1;
          end
        end
        ACK: begin
          if (clk_fall) begin
            // device pulls data low to acknowledge
            tx_done  <= ~data_sync[1];
            tx_noack <= data_sync[1];
            state    <= IDLE;
          end else if (timed_out) begin
            tx_noack <= 1'b1;
            state    <= IDLE;
          end else begin
            tmr <= tmr + 1'b1;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // command byte plus odd parity, ones shift in behind for the stop bit
  always_ff @(posedge clk) begin
    if (state == IDLE && tx_start) begin
      tx_shift <= {~^(`PS2_CMD_ENABLE), `PS2_CMD_ENABLE};
    end else if (state == SEND && clk_fall) begin
      tx_shift <= {1'b1, tx_shift[8:1]};
    end
  end

endmodule

// File: design/ps2_packet_asm.sv
// --------------------
// PS/2 mouse startup sequencer and packet assembler
// --------------------
`timescale 1ns/10ps
`include "ps2_consts.svh"

module ps2_packet_asm import ps2_pkg::*; (
  input  logic          clk,
  input  logic          arst_n,
  input  logic [7:0]    rx_byte,
  input  logic          rx_valid,
  input  logic          rx_err,
  input  logic          tx_done,
  input  logic          tx_noack,
  output logic          tx_start,
  output logic          streaming,
  output logic          init_error,
  output mouse_motion_t motion,
  output logic          motion_valid
);

  typedef enum logic [2:0] {
    S_SEND,
    S_WAIT_TX,
    S_WAIT_ACK,
    S_STREAM,
    S_FAIL
  } asm_state_t;

  asm_state_t state;
  logic [1:0] byte_idx;
  logic [7:0] hdr_q;
  logic [7:0] dx_q;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state        <= S_SEND;
      tx_start     <= 1'b0;
      streaming    <= 1'b0;
      init_error   <= 1'b0;
      byte_idx     <= '0;
      motion_valid <= 1'b0;
    end else begin
      tx_start     <= 1'b0;
      motion_valid <= 1'b0;
      case (state)
        S_SEND: begin
          // first cycle out of reset, ask for streaming
          tx_start <= 1'b1;
          state    <= S_WAIT_TX;
        end
        S_WAIT_TX: begin
          if (tx_noack) begin
            init_error <= 1'b1;
            state      <= S_FAIL;
          end else if (tx_done) begin
            state <= S_WAIT_ACK;
          end
        end
        S_WAIT_ACK: begin
          // other bytes before the ack are dropped
          if (rx_valid && rx_byte == `PS2_ACK_BYTE) begin
            streaming <= 1'b1;
            byte_idx  <= '0;
            state     <= S_STREAM;
          end
        end
        S_STREAM: begin
          if (rx_err) begin
            byte_idx <= '0;
          end else if (rx_valid) begin
            case (byte_idx)
              // bit 3 of the header is always set, use it to resync
              2'd0: byte_idx <= rx_byte[3] ? 2'd1 : 2'd0;
              2'd1: byte_idx <= 2'd2;
              default: begin
                byte_idx     <= 2'd0;
                motion_valid <= 1'b1;
              end
            endcase
          end
        end
        S_FAIL: state <= S_FAIL;
        default: state <= S_SEND;
      endcase
    end
  end

  // packet payload
  always_ff @(posedge clk) begin
    if (state == S_STREAM && rx_valid) begin
      case (byte_idx)
        2'd0: hdr_q <= rx_byte;
        2'd1: dx_q <= rx_byte;
        default: begin
          motion.btn <= '{left: hdr_q[0], middle: hdr_q[2], right: hdr_q[1]};
          motion.dx  <= {hdr_q[4], dx_q};
          motion.dy  <= {hdr_q[5], rx_byte};
          motion.ovf <= '{x_ovf: hdr_q[6], y_ovf: hdr_q[7]};
        end
      endcase
    end
  end

endmodule

// File: design/mouse_xy_tracker.sv
// --------------------
// absolute cursor tracker
// saturating x/y integration, y flipped for video
// --------------------
`timescale 1ns/10ps
`include "ps2_consts.svh"

module mouse_xy_tracker import ps2_pkg::*; #(
  parameter int MAX_X = `PS2_MAX_X,
  parameter int MAX_Y = `PS2_MAX_Y
) (
  input  logic          clk,
  input  logic          arst_n,
  input  mouse_motion_t motion,
  input  logic          motion_valid,
  output xy_pos_t       pos,
  output mouse_btn_t    btn,
  output logic          pos_valid
);

  localparam int POS_W = `PS2_POS_W;
  localparam logic [POS_W-1:0] LIM_X = POS_W'(MAX_X);
  localparam logic [POS_W-1:0] LIM_Y = POS_W'(MAX_Y);

  logic [8:0]       mag_x;
  logic [8:0]       mag_y;
  logic [POS_W-1:0] next_x;
  logic [POS_W-1:0] next_y;

  // move cur by mag toward lim (up) or toward 0, clamping at either end
  function automatic logic [POS_W-1:0] step_axis(
    input logic [POS_W-1:0] cur,
    input logic [8:0]       mag,
    input logic             up,
    input logic [POS_W-1:0] lim
  );
    logic [POS_W:0] sum;
    logic [POS_W:0] mag_ext;
    mag_ext = (POS_W+1)'(mag);
    sum     = {1'b0, cur} + mag_ext;
    if (up) begin
      step_axis = (sum >= {1'b0, lim}) ? lim : sum[POS_W-1:0];
    end else begin
      step_axis = ({1'b0, cur} <= mag_ext) ? '0 : cur - mag_ext[POS_W-1:0];
    end
  endfunction

  // magnitude of each delta, -256 gives 9'h100
  assign mag_x = motion.dx[8] ? (~motion.dx + 9'd1) : motion.dx;
  assign mag_y = motion.dy[8] ? (~motion.dy + 9'd1) : motion.dy;

  // x grows with positive dx, y grows with negative dy
  // an axis with its overflow flag set holds still
  assign next_x = motion.ovf.x_ovf ? pos.x : step_axis(pos.x, mag_x, ~motion.dx[8], LIM_X);
  assign next_y = motion.ovf.y_ovf ? pos.y : step_axis(pos.y, mag_y, motion.dy[8], LIM_Y);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pos       <= '0;
      btn       <= '0;
      pos_valid <= 1'b0;
    end else begin
      pos_valid <= motion_valid;
      if (motion_valid) begin
        pos.x <= next_x;
        pos.y <= next_y;
        btn   <= motion.btn;
      end
    end
  end

endmodule

// File: design/ps2_mouse_top.sv
// --------------------
// PS/2 mouse cursor front end, top level
// --------------------
`timescale 1ns/10ps
`include "ps2_consts.svh"

module ps2_mouse_top import ps2_pkg::*; (
  input  logic       clk,
  input  logic       arst_n,
  input  logic       ps2_clk_in,
  input  logic       ps2_data_in,
  output logic       ps2_clk_oe,
  output logic       ps2_data_oe,
  output xy_pos_t    pos,
  output mouse_btn_t btn,
  output logic       pos_valid,
  output logic       streaming,
  output logic       init_error
);

  // receiver to assembler
  logic [7:0]    rx_byte;
  logic          rx_valid;
  logic          rx_err;
  logic          clk_fall;
  // transmitter status
  logic          tx_start;
  logic          tx_busy;
  logic          tx_done;
  logic          tx_noack;
  // assembler to tracker
  mouse_motion_t motion;
  logic          motion_valid;

  ps2_frame_rx u_frame_rx (
    .clk         (clk),
    .arst_n      (arst_n),
    .ps2_clk_in  (ps2_clk_in),
    .ps2_data_in (ps2_data_in),
    .tx_busy     (tx_busy),
    .rx_byte     (rx_byte),
    .rx_valid    (rx_valid),
    .rx_err      (rx_err),
    .clk_fall    (clk_fall)
  );

  ps2_cmd_tx u_cmd_tx (
    .clk         (clk),
    .arst_n      (arst_n),
    .tx_start    (tx_start),
    .clk_fall    (clk_fall),
    .ps2_data_in (ps2_data_in),
    .ps2_clk_oe  (ps2_clk_oe),
    .ps2_data_oe (ps2_data_oe),
    .tx_busy     (tx_busy),
    .tx_done     (tx_done),
    .tx_noack    (tx_noack)
  );

  ps2_packet_asm u_packet_asm (
    .clk          (clk),
    .arst_n       (arst_n),
    .rx_byte      (rx_byte),
    .rx_valid     (rx_valid),
    .rx_err       (rx_err),
    .tx_done      (tx_done),
    .tx_noack     (tx_noack),
    .tx_start     (tx_start),
    .streaming    (streaming),
    .init_error   (init_error),
    .motion       (motion),
    .motion_valid (motion_valid)
  );

  mouse_xy_tracker #(
    .MAX_X (`PS2_MAX_X),
    .MAX_Y (`PS2_MAX_Y)
  ) u_xy_tracker (
    .clk          (clk),
    .arst_n       (arst_n),
    .motion       (motion),
    .motion_valid (motion_valid),
    .pos          (pos),
    .btn          (btn),
    .pos_valid    (pos_valid)
  );

endmodule

// File: testbench/tb_ps2_device.sv
// --------------------
// behavioral PS/2 mouse on open-drain lines
// sends device frames, captures and acknowledges the host command
// --------------------
`timescale 1ns/10ps

module tb_ps2_device (
  input  logic clk,
  input  logic dut_clk_oe,
  input  logic dut_data_oe,
  output logic ps2_clk,
  output logic ps2_data
);

  // device clock half period, 40 us
  localparam int HALF_NS = 40000;
  // idle line time after each frame
  localparam int GAP_NS  = 100000;

  logic clk_pull = 1'b0;
  logic data_pull = 1'b0;

  // wired AND, either side may pull low
  assign ps2_clk  = ~(dut_clk_oe | clk_pull);
  assign ps2_data = ~(dut_data_oe | data_pull);

  // one device-to-host frame, start, d0..d7, odd parity, stop
  // bad_parity flips the parity bit
  task automatic send_frame(input logic [7:0] data, input logic bad_parity);
    logic [10:0] bits;
    bits = {1'b1, (~^data) ^ bad_parity, data, 1'b0};
    // line changes stay on the falling clk edge
    @(negedge clk);
    for (int i = 0; i < 11; i++) begin
      data_pull = ~bits[i];
      #(HALF_NS / 2);
      clk_pull = 1'b1;
      #(HALF_NS);
      clk_pull = 1'b0;
      #(HALF_NS / 2);
    end
    data_pull = 1'b0;
    #(GAP_NS);
  endtask

  // waits for the host request-to-send and clocks the command in
  // host_bits holds d0..d7, parity and stop as read on rising edges
  // ack = 0 leaves data released during the acknowledge clock
  task automatic receive_command(input logic ack, output logic [9:0] host_bits,
                                 output logic start_ok);
    // inhibit, then clock released with data held low
    wait (ps2_clk === 1'b0);
    wait (ps2_clk === 1'b1);
    @(negedge clk);
    start_ok = (ps2_data === 1'b0);
    #(HALF_NS / 2);
    for (int i = 0; i < 10; i++) begin
      clk_pull = 1'b1;
      #(HALF_NS);
      clk_pull = 1'b0;
      // host data is stable by the rising edge
      host_bits[i] = ps2_data;
      if (i == 9) begin
        data_pull = ack;
      end
      #(HALF_NS);
    end
    // acknowledge clock
    clk_pull = 1'b1;
    #(HALF_NS);
    clk_pull = 1'b0;
    #(HALF_NS);
    data_pull = 1'b0;
    #(GAP_NS);
  endtask

endmodule

// File: testbench/tb_ps2_mouse.sv
// --------------------
// PS/2 mouse front end testbench
// startup, motion, clamping, buttons, bad frames, missing ack
// --------------------
`timescale 1ns/10ps
`include "ps2_consts.svh"

module tb_ps2_mouse import ps2_pkg::*; ();

  localparam int N_RAND  = 20;
  localparam int N_CLAMP = 6;
  localparam int N_BTN   = 6;
  // time for one frame plus its gap in ns rounded up
  localparam longint FRAME_NS = 1000000;
  // two commands at two frame times each, ack, packets, bad frames, idle wait
  localparam int TOTAL_FRAMES = 4 + 1 + 3 * N_RAND + 12 * N_CLAMP + 3 * N_BTN + 8 + 1;
  localparam longint WATCHDOG_NS = longint'(TOTAL_FRAMES) * FRAME_NS + 5000000;
  // clk cycles allowed for one frame worth of waiting
  localparam int WAIT_CYCLES = 10000;

  logic       clk;
  logic       arst_n;
  wire        ps2_clk;
  wire        ps2_data;
  logic       ps2_clk_oe;
  logic       ps2_data_oe;
  xy_pos_t    pos;
  mouse_btn_t btn;
  logic       pos_valid;
  logic       streaming;
  logic       init_error;

  int         checks = 0;
  int         errors = 0;
  int         valid_cnt = 0;
  xy_pos_t    seen_pos;
  mouse_btn_t seen_btn;
  // reference cursor state
  int         ref_x = 0;
  int         ref_y = 0;
  mouse_btn_t ref_btn = '0;

  ps2_mouse_top dut (
    .clk         (clk),
    .arst_n      (arst_n),
    .ps2_clk_in  (ps2_clk),
    .ps2_data_in (ps2_data),
    .ps2_clk_oe  (ps2_clk_oe),
    .ps2_data_oe (ps2_data_oe),
    .pos         (pos),
    .btn         (btn),
    .pos_valid   (pos_valid),
    .streaming   (streaming),
    .init_error  (init_error)
  );

  tb_ps2_device dev (
    .clk         (clk),
    .dut_clk_oe  (ps2_clk_oe),
    .dut_data_oe (ps2_data_oe),
    .ps2_clk     (ps2_clk),
    .ps2_data    (ps2_data)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // latch every position update mid-cycle
  always @(negedge clk) begin
    if (pos_valid === 1'b1) begin
      valid_cnt <= valid_cnt + 1;
      seen_pos  <= pos;
      seen_btn  <= btn;
    end
  end

  task automatic check_pos(input string name, input xy_pos_t got, input xy_pos_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %s: got x=%h y=%h, expected x=%h y=%h", name, got.x, got.y, exp.x, exp.y);
    end
  endtask

  task automatic check_btn(input string name, input mouse_btn_t got, input mouse_btn_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %s: got %h, expected %h", name, got, exp);
    end
  endtask

  function automatic int clamp_to_range(input int v, input int hi);
    if (v < 0) begin
      return 0;
    end
    return (v > hi) ? hi : v;
  endfunction

  function automatic xy_pos_t expected_pos();
    xy_pos_t p;
    p.x = `PS2_POS_W'(ref_x);
    p.y = `PS2_POS_W'(ref_y);
    return p;
  endfunction

  // reference packet rules with y flipped and an overflowed axis held
  task automatic apply_reference(input logic [7:0] hdr, input logic [7:0] b1,
                                 input logic [7:0] b2);
    int dx;
    int dy;
    dx = hdr[4] ? int'(b1) - 256 : int'(b1);
    dy = hdr[5] ? int'(b2) - 256 : int'(b2);
    ref_btn.left   = hdr[0];
    ref_btn.right  = hdr[1];
    ref_btn.middle = hdr[2];
    if (!hdr[6]) begin
      ref_x = clamp_to_range(ref_x + dx, `PS2_MAX_X);
    end
    if (!hdr[7]) begin
      ref_y = clamp_to_range(ref_y - dy, `PS2_MAX_Y);
    end
  endtask

  task automatic apply_reset();
    arst_n = 1'b0;
    repeat (5) @(negedge clk);
    arst_n = 1'b1;
    ref_x   = 0;
    ref_y   = 0;
    ref_btn = '0;
  endtask

  // sends one 3-byte packet and checks the update it causes
  task automatic send_packet(input logic [7:0] hdr, input logic [7:0] b1, input logic [7:0] b2);
    int prev;
    int n;
    @(posedge clk);
    prev = valid_cnt;
    dev.send_frame(hdr, 1'b0);
    dev.send_frame(b1, 1'b0);
    dev.send_frame(b2, 1'b0);
    for (n = 0; n < WAIT_CYCLES && valid_cnt == prev; n++) begin
      @(posedge clk);
    end
    apply_reference(hdr, b1, b2);
    if (valid_cnt != prev + 1) begin
      errors++;
      $display("packet %h %h %h gave %0d position updates instead of one",
               hdr, b1, b2, valid_cnt - prev);
    end else begin
      check_pos("pos", seen_pos, expected_pos());
      check_btn("btn", seen_btn, ref_btn);
    end
  endtask

  task automatic startup_handshake();
    logic [9:0] host_bits;
    logic       start_ok;
    int         n;
    // everything idle straight out of reset
    check_flag("ps2_clk_oe", ps2_clk_oe, 1'b0);
    check_flag("ps2_data_oe", ps2_data_oe, 1'b0);
    check_flag("pos_valid", pos_valid, 1'b0);
    check_flag("streaming", streaming, 1'b0);
    check_flag("init_error", init_error, 1'b0);
    dev.receive_command(1'b1, host_bits, start_ok);
    check_flag("start bit", start_ok, 1'b1);
    check_byte("command", host_bits[7:0], `PS2_CMD_ENABLE);
    // odd parity over the byte and its parity bit
    check_flag("command parity", ^host_bits[8:0], 1'b1);
    check_flag("command stop bit", host_bits[9], 1'b1);
    dev.send_frame(`PS2_ACK_BYTE, 1'b0);
    for (n = 0; n < WAIT_CYCLES && streaming !== 1'b1; n++) begin
      @(negedge clk);
    end
    check_flag("streaming", streaming, 1'b1);
    check_flag("init_error", init_error, 1'b0);
  endtask

  task automatic random_motion();
    logic [31:0] r;
    for (int k = 0; k < N_RAND; k++) begin
      r = $urandom;
      // random buttons and signs with the sync bit set and no overflow
      send_packet({2'b00, r[20:19], 1'b1, r[18:16]}, r[7:0], r[15:8]);
    end
  endtask

  task automatic edge_clamping();
    xy_pos_t edge_pos;
    // +255 in x toward the right edge
    for (int k = 0; k < N_CLAMP; k++) begin
      send_packet(8'h08, 8'hFF, 8'h00);
    end
    edge_pos   = expected_pos();
    edge_pos.x = `PS2_POS_W'(`PS2_MAX_X);
    check_pos("pos", seen_pos, edge_pos);
    // -256 in x toward the left edge
    for (int k = 0; k < N_CLAMP; k++) begin
      send_packet(8'h18, 8'h00, 8'h00);
    end
    edge_pos.x = '0;
    check_pos("pos", seen_pos, edge_pos);
    // negative dy moves the cursor down the screen
    for (int k = 0; k < N_CLAMP; k++) begin
      send_packet(8'h28, 8'h00, 8'h00);
    end
    edge_pos.y = `PS2_POS_W'(`PS2_MAX_Y);
    check_pos("pos", seen_pos, edge_pos);
    // positive dy brings it back to the top edge
    for (int k = 0; k < N_CLAMP; k++) begin
      send_packet(8'h08, 8'h00, 8'hFF);
    end
    edge_pos.y = '0;
    check_pos("pos", seen_pos, edge_pos);
  endtask

  task automatic buttons_and_overflow();
    logic [7:0] hdrs [N_BTN];
    // each button alone and then x, y and both overflow flags
    // dy is negative so y walks away from the top edge
    hdrs = '{8'h29, 8'h2A, 8'h2C, 8'h68, 8'hAF, 8'hE8};
    for (int k = 0; k < N_BTN; k++) begin
      send_packet(hdrs[k], 8'h20, 8'hF0);
    end
  endtask

  task automatic bad_frame_recovery();
    int prev;
    @(posedge clk);
    prev = valid_cnt;
    // header then a byte with broken parity restarts the packet
    dev.send_frame(8'h09, 1'b0);
    dev.send_frame(8'h10, 1'b1);
    // none of these may be taken as a header
    dev.send_frame(8'h01, 1'b0);
    dev.send_frame(8'h05, 1'b0);
    dev.send_frame(8'h03, 1'b0);
    @(negedge clk);
    if (valid_cnt != prev) begin
      errors++;
      $display("position updated after a bad parity frame or an unsynced header");
    end
    check_pos("pos", pos, expected_pos());
    send_packet(8'h0B, 8'h40, 8'hE0);
  endtask

  task automatic missing_ack();
    logic [9:0] host_bits;
    logic       start_ok;
    int         n;
    apply_reset();
    dev.receive_command(1'b0, host_bits, start_ok);
    check_flag("start bit", start_ok, 1'b1);
    check_byte("command", host_bits[7:0], `PS2_CMD_ENABLE);
    for (n = 0; n < WAIT_CYCLES && init_error !== 1'b1; n++) begin
      @(negedge clk);
    end
    check_flag("init_error", init_error, 1'b1);
    #(FRAME_NS);
    check_flag("streaming", streaming, 1'b0);
    check_flag("init_error", init_error, 1'b1);
  endtask

  initial begin
    void'($urandom(32'hb349));
    arst_n = 1'b0;
    apply_reset();
    startup_handshake();
    random_motion();
    edge_clamping();
    buttons_and_overflow();
    bad_frame_recovery();
    missing_ack();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  // bounds the whole run
  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired before the tests finished");
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

// File: src.f
+incdir+include
design/ps2_pkg.sv
design/ps2_frame_rx.sv
design/ps2_cmd_tx.sv
design/ps2_packet_asm.sv
design/mouse_xy_tracker.sv
design/ps2_mouse_top.sv
testbench/tb_ps2_device.sv
testbench/tb_ps2_mouse.sv

// File: build.sh
#!/bin/sh
# build and run the PS/2 mouse testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_ps2_mouse -f src.f -o tb_sim
./obj_dir/tb_sim | tee sim.log

if grep -q "^STATUS: PASS$" sim.log; then
  exit 0
fi
echo "simulation did not pass, see sim.log"
exit 1
